// ==== display_pkg.sv ====
// display geometry constants, address and colour types
// and the byte-address function shared by the drawing back end
package display_pkg;

    // ========================================================================
    // screen geometry
    // ========================================================================
    localparam int COLUMNS         = 16;
    localparam int ROWS            = 8;
    localparam int BYTES_PER_PIXEL = 3;
    localparam int FB_BYTES        = COLUMNS * ROWS * BYTES_PER_PIXEL;  // 384 bytes

    typedef logic [$clog2(COLUMNS)-1:0]         col_addr_t;        // column index
    typedef logic [$clog2(COLUMNS):0]           col_addr_count_t;  // width, 1 to 16
    typedef logic [$clog2(ROWS)-1:0]            row_addr_t;        // row index
    typedef logic [$clog2(ROWS):0]              row_addr_count_t;  // height, 1 to 8
    typedef logic [$clog2(BYTES_PER_PIXEL)-1:0] pixel_addr_t;      // byte within a pixel
    typedef logic [$clog2(FB_BYTES)-1:0]        fb_addr_t;         // framebuffer byte address

    // byte 2 is the first byte of a pixel to go out on the write bus
    typedef struct packed {
        logic [BYTES_PER_PIXEL-1:0][7:0] bytes;
    } color_field_t;

    // ========================================================================
    // byte address of one pixel byte, pixels stored row by row
    // ========================================================================
    function automatic fb_addr_t fb_byte_address(
        input row_addr_t   row,
        input col_addr_t   column,
        input pixel_addr_t pixel
    );
        int linear;
        linear = (int'(row) * COLUMNS + int'(column)) * BYTES_PER_PIXEL + int'(pixel);
        return fb_addr_t'(linear);
    endfunction

endpackage

// ==== ram_write_if.sv ====
// single byte write to the framebuffer, with source and sink modports
`timescale 1ns/1ps

interface ram_write_if;
    import display_pkg::*;

    row_addr_t   row;           // pixel row of the byte
    col_addr_t   column;        // pixel column of the byte
    pixel_addr_t pixel;         // byte index inside the pixel
    logic [7:0]  data;
    logic        write_enable;  // one byte written per edge while high

    modport source (
        output row, column, pixel, data, write_enable
    );

    modport sink (
        input row, column, pixel, data, write_enable
    );

endinterface

// ==== fill_area_engine.sv ====
// rectangle fill FSM, walks from the bottom-right pixel to the top-left
// one and writes every pixel's bytes from the highest byte down
`timescale 1ns/1ps

module fill_area_engine (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         enable,
    input  logic                         ack,
    input  display_pkg::col_addr_t       x1,
    input  display_pkg::row_addr_t       y1,
    input  display_pkg::col_addr_count_t width,
    input  display_pkg::row_addr_count_t height,
    input  display_pkg::color_field_t    color,
    ram_write_if.source                  wr,
    output logic                         done
);
    import display_pkg::*;

    localparam pixel_addr_t TOP_PIXEL = pixel_addr_t'(BYTES_PER_PIXEL - 1);

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        WAIT_ACK
    } fill_state_t;

    fill_state_t state;
    col_addr_t   x_last;     // right edge of the rectangle
    row_addr_t   y_last;     // bottom edge of the rectangle
    logic        last_byte;  // bus holds byte 0 of the top-left pixel

    assign x_last    = col_addr_t'(x1 + width - 1'b1);
    assign y_last    = row_addr_t'(y1 + height - 1'b1);
    assign last_byte = (wr.row == y1) && (wr.column == x1) && (wr.pixel == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= IDLE;
            wr.write_enable <= 1'b0;
            done            <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (enable) begin
                        wr.row          <= y_last;  // start at the bottom-right corner
                        wr.column       <= x_last;
                        wr.pixel        <= TOP_PIXEL;
                        wr.data         <= color.bytes[BYTES_PER_PIXEL-1];
                        wr.write_enable <= 1'b1;
                        state           <= WRITE;
                    end
                end
                WRITE: begin
                    if (last_byte) begin
                        wr.write_enable <= 1'b0;  // last byte went out on the previous edge
                        if (ack) begin
                            done  <= 1'b0;
                            state <= IDLE;
                        end else begin
                            state <= WAIT_ACK;
                        end
                    end else if (enable) begin
                        if (wr.pixel == '0) begin
                            wr.pixel <= TOP_PIXEL;
                            wr.data  <= color.bytes[BYTES_PER_PIXEL-1];
                            if (wr.column == x1) begin
                                wr.column <= x_last;  // wrap to the right edge, one row up
                                wr.row    <= wr.row - 1'b1;
                            end else begin
                                wr.column <= wr.column - 1'b1;
                            end
                        end else begin
                            wr.pixel <= wr.pixel - 1'b1;
                            wr.data  <= color.bytes[pixel_addr_t'(wr.pixel - 1'b1)];
                            // done goes up together with the final byte
                            if (wr.row == y1 && wr.column == x1 && wr.pixel == pixel_addr_t'(1)) begin
                                done <= 1'b1;
                            end
                        end
                    end
                end
                WAIT_ACK: begin
                    if (ack) begin
                        done  <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== pixel_stream_writer.sv ====
// window-write engine, places host bytes in row-major order from the
// top-left pixel, highest byte of each pixel first
`timescale 1ns/1ps

module pixel_stream_writer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  display_pkg::col_addr_t       x1,
    input  display_pkg::row_addr_t       y1,
    input  display_pkg::col_addr_count_t width,
    input  display_pkg::row_addr_count_t height,
    input  logic                         valid,
    input  logic [7:0]                   data_in,
    ram_write_if.source                  wr,
    output logic                         done
);
    import display_pkg::*;

    localparam pixel_addr_t TOP_PIXEL = pixel_addr_t'(BYTES_PER_PIXEL - 1);

    col_addr_t   win_x1;      // left edge, reloaded at each row wrap
    col_addr_t   win_x_last;
    row_addr_t   win_y_last;
    row_addr_t   cur_row;     // position of the next accepted byte
    col_addr_t   cur_col;
    pixel_addr_t cur_pixel;
    logic        active;      // window open and not yet full
    logic        window_end;

    assign window_end = (cur_row == win_y_last) && (cur_col == win_x_last) && (cur_pixel == '0);

    // window corners are captured once per start
    always_ff @(posedge clk) begin
        if (start) begin
            win_x1     <= x1;
            win_x_last <= col_addr_t'(x1 + width - 1'b1);
            win_y_last <= row_addr_t'(y1 + height - 1'b1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active          <= 1'b0;
            wr.write_enable <= 1'b0;
            done            <= 1'b0;
        end else begin
            wr.write_enable <= 1'b0;
            done            <= 1'b0;
            if (start) begin
                active    <= 1'b1;
                cur_row   <= y1;
                cur_col   <= x1;
                cur_pixel <= TOP_PIXEL;
            end else if (active && valid) begin
                wr.row          <= cur_row;
                wr.column       <= cur_col;
                wr.pixel        <= cur_pixel;
                wr.data         <= data_in;
                wr.write_enable <= 1'b1;
                if (window_end) begin
                    active <= 1'b0;  // further bytes are ignored until the next start
                    done   <= 1'b1;
                end else if (cur_pixel != '0) begin
                    cur_pixel <= cur_pixel - 1'b1;
                end else begin
                    cur_pixel <= TOP_PIXEL;
                    if (cur_col == win_x_last) begin
                        cur_col <= win_x1;
                        cur_row <= cur_row + 1'b1;
                    end else begin
                        cur_col <= cur_col + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== fb_write_arbiter.sv ====
// registered merge of the fill and stream write buses, fill has priority
`timescale 1ns/1ps

module fb_write_arbiter (
    input  logic         clk,
    input  logic         reset,
    ram_write_if.sink    fill_wr,
    ram_write_if.sink    stream_wr,
    ram_write_if.source  ram_wr,
    output logic         write_dropped
);

    // ========================================================================
    // one register stage between the engines and the RAM
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            ram_wr.write_enable <= 1'b0;
            write_dropped       <= 1'b0;
        end else begin
            write_dropped <= fill_wr.write_enable && stream_wr.write_enable;  // stream byte lost
            if (fill_wr.write_enable) begin
                ram_wr.row          <= fill_wr.row;
                ram_wr.column       <= fill_wr.column;
                ram_wr.pixel        <= fill_wr.pixel;
                ram_wr.data         <= fill_wr.data;
                ram_wr.write_enable <= 1'b1;
            end else begin
                ram_wr.row          <= stream_wr.row;
                ram_wr.column       <= stream_wr.column;
                ram_wr.pixel        <= stream_wr.pixel;
                ram_wr.data         <= stream_wr.data;
                ram_wr.write_enable <= stream_wr.write_enable;
            end
        end
    end

endmodule

// ==== framebuffer_ram.sv ====
// 384-byte framebuffer, synchronous byte write and registered host read
`timescale 1ns/1ps

module framebuffer_ram (
    input  logic                     clk,
    ram_write_if.sink                wr,
    input  display_pkg::row_addr_t   rd_row,
    input  display_pkg::col_addr_t   rd_column,
    input  display_pkg::pixel_addr_t rd_pixel,
    output logic [7:0]               rd_data
);
    import display_pkg::*;

    logic [7:0] mem [FB_BYTES];
    fb_addr_t   wr_addr;
    fb_addr_t   rd_addr;

    assign wr_addr = fb_byte_address(wr.row, wr.column, wr.pixel);
    assign rd_addr = fb_byte_address(rd_row, rd_column, rd_pixel);

    always_ff @(posedge clk) begin
        if (wr.write_enable) begin
            mem[wr_addr] <= wr.data;
        end
    end

    // read data shows up one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== display_ctrl.sv ====
// drawing back end top level, fill and stream engines merged by the
// write arbiter into the framebuffer RAM
`timescale 1ns/1ps

module display_ctrl (
    input  logic                         clk,
    input  logic                         reset,
    // fill engine
    input  logic                         fill_enable,
    input  logic                         fill_ack,
    input  display_pkg::col_addr_t       fill_x1,
    input  display_pkg::row_addr_t       fill_y1,
    input  display_pkg::col_addr_count_t fill_width,
    input  display_pkg::row_addr_count_t fill_height,
    input  display_pkg::color_field_t    fill_color,
    output logic                         fill_done,
    // stream writer
    input  logic                         stream_start,
    input  logic                         stream_valid,
    input  logic [7:0]                   stream_data,
    input  display_pkg::col_addr_t       stream_x1,
    input  display_pkg::row_addr_t       stream_y1,
    input  display_pkg::col_addr_count_t stream_width,
    input  display_pkg::row_addr_count_t stream_height,
    output logic                         stream_done,
    // arbiter status and host read port
    output logic                         write_dropped,
    input  display_pkg::row_addr_t       rd_row,
    input  display_pkg::col_addr_t       rd_column,
    input  display_pkg::pixel_addr_t     rd_pixel,
    output logic [7:0]                   rd_data
);

    ram_write_if fill_wr_if ();
    ram_write_if stream_wr_if ();
    ram_write_if ram_wr_if ();

    fill_area_engine fill_i (
        .clk    (clk),
        .reset  (reset),
        .enable (fill_enable),
        .ack    (fill_ack),
        .x1     (fill_x1),
        .y1     (fill_y1),
        .width  (fill_width),
        .height (fill_height),
        .color  (fill_color),
        .wr     (fill_wr_if.source),
        .done   (fill_done)
    );

    pixel_stream_writer stream_i (
        .clk     (clk),
        .reset   (reset),
        .start   (stream_start),
        .x1      (stream_x1),
        .y1      (stream_y1),
        .width   (stream_width),
        .height  (stream_height),
        .valid   (stream_valid),
        .data_in (stream_data),
        .wr      (stream_wr_if.source),
        .done    (stream_done)
    );

    fb_write_arbiter arbiter_i (
        .clk           (clk),
        .reset         (reset),
        .fill_wr       (fill_wr_if.sink),
        .stream_wr     (stream_wr_if.sink),
        .ram_wr        (ram_wr_if.source),
        .write_dropped (write_dropped)
    );

    framebuffer_ram ram_i (
        .clk       (clk),
        .wr        (ram_wr_if.sink),
        .rd_row    (rd_row),
        .rd_column (rd_column),
        .rd_pixel  (rd_pixel),
        .rd_data   (rd_data)
    );

endmodule

// ==== display_ctrl_props.sv ====
// write arbiter assertions, attached to every fb_write_arbiter by bind
`timescale 1ns/1ps

module display_ctrl_props (
    input logic clk,
    input logic reset,
    input logic fill_we,
    input logic stream_we,
    input logic ram_we,
    input logic write_dropped
);

    // a drop needs both engines on the bus one cycle earlier
    assert property (@(posedge clk) disable iff (reset)
        write_dropped |-> $past(fill_we && stream_we))
        else $error("write_dropped rose without two writers");

    assert property (@(posedge clk) disable iff (reset)
        stream_we && !fill_we |=> ram_we)  // lone stream byte must reach the RAM bus
        else $error("stream write lost although the fill engine was quiet");

    assert property (@(posedge clk) $past(reset) |-> !ram_we && !write_dropped)
        else $error("RAM write enable or write_dropped high after reset");

endmodule

bind fb_write_arbiter display_ctrl_props props_i (
    .clk           (clk),
    .reset         (reset),
    .fill_we       (fill_wr.write_enable),
    .stream_we     (stream_wr.write_enable),
    .ram_we        (ram_wr.write_enable),
    .write_dropped (write_dropped)
);

// ==== display_ctrl_checker.sv ====
// framebuffer and write timing model of the display controller, compares
// done strobes, dropped writes and read-back data against the DUT ports
`timescale 1ns/1ps

module display_ctrl_checker (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         fill_enable, fill_ack, fill_done,
    input  display_pkg::col_addr_t       fill_x1, stream_x1, rd_column,
    input  display_pkg::row_addr_t       fill_y1, stream_y1, rd_row,
    input  display_pkg::col_addr_count_t fill_width, stream_width,
    input  display_pkg::row_addr_count_t fill_height, stream_height,
    input  display_pkg::color_field_t    fill_color,
    input  display_pkg::pixel_addr_t     rd_pixel,
    input  logic                         stream_start, stream_valid, stream_done,
    input  logic [7:0]                   stream_data, rd_data,
    input  logic                         write_dropped,
    input  logic                         read_check,   // rd address of this cycle is checked
    input  logic                         case_end,     // pulse counts of the case are compared
    input  int                           exp_stream_done,
    input  int                           exp_dropped,
    output int                           errors
);
    import display_pkg::*;

    logic [7:0] model_fb [FB_BYTES];
    logic       fill_bus;     // fill engine has a write on its bus this cycle
    logic       done_exp;
    int         fill_left;    // fill bytes still to be presented
    logic       s_active;
    logic       s_bus;        // stream writer has a write on its bus this cycle
    fb_addr_t   s_addr;
    logic [7:0] s_data;
    logic       sdone_exp;
    logic       drop_exp;
    int         s_idx;        // next window byte, counted in row-major order
    int         s_total;
    int         s_w;
    col_addr_t  s_x1;
    row_addr_t  s_y1;
    logic       rd_pend;
    fb_addr_t   rd_addr_q;
    logic [7:0] rd_exp;
    int         sdone_count;
    int         drop_count;

    // ========================================================================
    // reference model, one update per clock edge
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            fill_bus  <= 1'b0;
            done_exp  <= 1'b0;
            fill_left <= 0;
            s_active  <= 1'b0;
            s_bus     <= 1'b0;
            sdone_exp <= 1'b0;
            drop_exp  <= 1'b0;
            rd_pend   <= 1'b0;
        end else begin
            if (!fill_bus && !done_exp && fill_enable) begin
                fill_bus  <= 1'b1;
                fill_left <= int'(fill_width) * int'(fill_height) * BYTES_PER_PIXEL - 1;
                for (int r = 0; r < int'(fill_height); r++) begin
                    for (int c = 0; c < int'(fill_width); c++) begin
                        for (int p = 0; p < BYTES_PER_PIXEL; p++) begin
                            model_fb[fb_byte_address(row_addr_t'(int'(fill_y1) + r),
                                col_addr_t'(int'(fill_x1) + c), pixel_addr_t'(p))]
                                <= fill_color.bytes[pixel_addr_t'(p)];
                        end
                    end
                end
            end else if (fill_bus && fill_left == 0) begin
                fill_bus <= 1'b0;  // the last byte was on the bus for one cycle
                if (fill_ack) begin
                    done_exp <= 1'b0;
                end
            end else if (fill_bus && fill_enable) begin
                fill_left <= fill_left - 1;
                if (fill_left == 1) begin
                    done_exp <= 1'b1;
                end
            end else if (!fill_bus && fill_ack) begin
                done_exp <= 1'b0;
            end

            // the fill engine wins a shared cycle and the stream byte is lost
            drop_exp  <= s_bus && fill_bus;
            s_bus     <= 1'b0;
            sdone_exp <= 1'b0;
            if (s_bus && !fill_bus) begin
                model_fb[s_addr] <= s_data;
            end
            if (stream_start) begin
                s_active <= 1'b1;
                s_idx    <= 0;
                s_x1     <= stream_x1;
                s_y1     <= stream_y1;
                s_w      <= int'(stream_width);
                s_total  <= int'(stream_width) * int'(stream_height) * BYTES_PER_PIXEL;
            end else if (s_active && stream_valid) begin
                s_bus  <= 1'b1;
                s_addr <= fb_byte_address(row_addr_t'(int'(s_y1) + s_idx / (s_w * BYTES_PER_PIXEL)),
                    col_addr_t'(int'(s_x1) + (s_idx / BYTES_PER_PIXEL) % s_w),
                    pixel_addr_t'(BYTES_PER_PIXEL - 1 - s_idx % BYTES_PER_PIXEL));
                s_data <= stream_data;
                s_idx  <= s_idx + 1;
                if (s_idx == s_total - 1) begin
                    s_active  <= 1'b0;
                    sdone_exp <= 1'b1;
                end
            end

            rd_pend <= read_check;
            if (read_check) begin
                rd_addr_q <= fb_byte_address(rd_row, rd_column, rd_pixel);
                rd_exp    <= model_fb[fb_byte_address(rd_row, rd_column, rd_pixel)];
            end
        end
    end

    // ========================================================================
    // comparison against the DUT outputs of the current cycle
    // ========================================================================
    always @(posedge clk) begin
        if (reset) begin
            errors      = 0;
            sdone_count = 0;
            drop_count  = 0;
        end else begin
            if (fill_done !== done_exp) begin
                $display("FAILED %0t: fill_done is %b, expected %b", $time, fill_done, done_exp);
                errors++;
            end
            if (stream_done !== sdone_exp) begin
                $display("FAILED %0t: stream_done is %b, expected %b", $time, stream_done,
                    sdone_exp);
                errors++;
            end
            if (write_dropped !== drop_exp) begin
                $display("FAILED %0t: write_dropped is %b, expected %b", $time, write_dropped,
                    drop_exp);
                errors++;
            end
            if (rd_pend && rd_data !== rd_exp) begin
                $display("FAILED %0t: byte %0d reads %h, expected %h", $time, rd_addr_q,
                    rd_data, rd_exp);
                errors++;
            end
            sdone_count += int'(stream_done);
            drop_count  += int'(write_dropped);
            if (case_end) begin
                if (sdone_count != exp_stream_done || drop_count != exp_dropped) begin
                    $display("FAILED %0t: %0d stream_done and %0d dropped, expected %0d and %0d",
                        $time, sdone_count, drop_count, exp_stream_done, exp_dropped);
                    errors++;
                end
                sdone_count = 0;
                drop_count  = 0;
            end
        end
    end

endmodule

// ==== tb_display_ctrl.sv ====
// testbench top, clock and reset, cases file reader, stimulus on the
// falling clock edge and one result line per case
`timescale 1ns/1ps

module tb_display_ctrl;
    import display_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;

    logic            clk;
    logic            reset;
    logic            fill_enable, fill_ack, fill_done;
    col_addr_t       fill_x1, stream_x1, rd_column;
    row_addr_t       fill_y1, stream_y1, rd_row;
    col_addr_count_t fill_width, stream_width;
    row_addr_count_t fill_height, stream_height;
    color_field_t    fill_color;
    pixel_addr_t     rd_pixel;
    logic            stream_start, stream_valid, stream_done;
    logic [7:0]      stream_data, rd_data;
    logic            write_dropped;
    logic            read_check;
    logic            case_end;
    int              exp_stream_done;
    int              exp_dropped;
    int              errors;
    int              seed;
    bit              aborted;  // run cannot go on, reported at the end

    display_ctrl display_ctrl_i (.*);

    display_ctrl_checker checker_i (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // one fill, with an optional enable gap and stream bytes sent alongside
    task automatic run_fill(input int x, y, w, h, color, gap, stream_bytes);
        int total;
        int n;
        total       = w * h * BYTES_PER_PIXEL;
        fill_x1     = col_addr_t'(x);
        fill_y1     = row_addr_t'(y);
        fill_width  = col_addr_count_t'(w);
        fill_height = row_addr_count_t'(h);
        fill_color  = color_field_t'(color[23:0]);
        for (n = 0; n < TIMEOUT_CYCLES && !fill_done; n++) begin
            fill_enable  = !(n >= total / 2 && n < total / 2 + gap);
            stream_valid = n >= 1 && n <= stream_bytes;
            stream_data  = 8'($random(seed));
            @(negedge clk);
        end
        fill_enable  = 1'b0;
        stream_valid = 1'b0;
        if (!fill_done) begin
            $display("timeout, fill_done did not rise within %0d cycles", TIMEOUT_CYCLES);
            aborted = 1'b1;
        end else begin
            repeat (2) @(negedge clk);  // done has to hold until the ack
            fill_ack = 1'b1;
            @(negedge clk);
            fill_ack = 1'b0;
        end
    endtask

    task automatic run_stream(input int x, y, w, h, bytes);
        stream_x1     = col_addr_t'(x);
        stream_y1     = row_addr_t'(y);
        stream_width  = col_addr_count_t'(w);
        stream_height = row_addr_count_t'(h);
        stream_start  = 1'b1;
        @(negedge clk);
        stream_start = 1'b0;
        for (int n = 0; n < bytes; n++) begin
            stream_valid = 1'b1;
            stream_data  = 8'($random(seed));
            @(negedge clk);
        end
        stream_valid = 1'b0;
    endtask

    task automatic read_screen();
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLUMNS; c++) begin
                for (int p = 0; p < BYTES_PER_PIXEL; p++) begin
                    rd_row     = row_addr_t'(r);
                    rd_column  = col_addr_t'(c);
                    rd_pixel   = pixel_addr_t'(p);
                    read_check = 1'b1;
                    @(negedge clk);
                end
            end
        end
        read_check = 1'b0;
    endtask

    initial begin
        string line;
        int    fd;
        int    op, x, y, w, h, color, gap, extra, n_done, n_drop;
        int    case_no;
        int    errors_before;
        seed            = 32'h9d0b1468;
        reset           = 1'b1;
        fill_enable     = 1'b0;
        fill_ack        = 1'b0;
        fill_x1         = '0;
        fill_y1         = '0;
        fill_width      = '0;
        fill_height     = '0;
        fill_color      = '0;
        stream_start    = 1'b0;
        stream_valid    = 1'b0;
        stream_data     = '0;
        stream_x1       = '0;
        stream_y1       = '0;
        stream_width    = '0;
        stream_height   = '0;
        rd_row          = '0;
        rd_column       = '0;
        rd_pixel        = '0;
        read_check      = 1'b0;
        case_end        = 1'b0;
        exp_stream_done = 0;
        exp_dropped     = 0;
        aborted         = 1'b0;
        case_no         = 0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        fd = $fopen("display_ctrl_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open display_ctrl_cases.txt");
            aborted = 1'b1;
        end
        while (!aborted && $fgets(line, fd) != 0) begin
            if (line.getc(0) != "#" && $sscanf(line, "%d %d %d %d %d %h %d %d %d %d",
                    op, x, y, w, h, color, gap, extra, n_done, n_drop) == 10) begin
                case_no++;
                errors_before = errors;
                case (op)
                    0: read_screen();
                    1: run_fill(x, y, w, h, color, gap, 0);
                    2: run_stream(x, y, w, h, w * h * BYTES_PER_PIXEL + extra);
                    3: run_fill(x, y, w, h, color, gap, extra);
                    4: run_stream(x, y, w, h, 0);
                    default: begin
                        $display("case %0d has an unknown operation %0d", case_no, op);
                        aborted = 1'b1;
                    end
                endcase
                repeat (4) @(negedge clk);  // arbiter and RAM pipeline drain
                exp_stream_done = n_done;
                exp_dropped     = n_drop;
                case_end        = 1'b1;
                @(negedge clk);
                case_end = 1'b0;
                $display("case %0d, operation %0d: %s", case_no, op,
                    (errors == errors_before) ? "ok" : "mismatch");
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("%0d cases run, %0d checks failed", case_no, errors);
        if (errors == 0 && !aborted && case_no > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== display_ctrl.f ====
display_pkg.sv
ram_write_if.sv
fill_area_engine.sv
pixel_stream_writer.sv
fb_write_arbiter.sv
framebuffer_ram.sv
display_ctrl.sv
display_ctrl_props.sv
display_ctrl_checker.sv
tb_display_ctrl.sv

// ==== Makefile ====
# Verilator build and run of the display controller testbench

sim:
	verilator --binary --assert --timescale 1ns/1ps --top-module tb_display_ctrl -f display_ctrl.f --Mdir obj_dir
	@out="$$(./obj_dir/Vtb_display_ctrl)"; echo "$$out"; echo "$$out" | grep -qF "All tests passed!"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== display_ctrl_cases.txt ====
# op x1 y1 width height color(hex) gap extra stream_dones drops
# op: 0 read back screen, 1 fill, 2 stream window, 3 fill with stream bytes, 4 stream start only
1 0 0 16 8 a1b2c3 0 0 0 0
0 0 0 0 0 0 0 0 0 0
1 5 2 3 2 102030 0 0 0 0
0 0 0 0 0 0 0 0 0 0
1 1 1 2 1 445566 0 0 0 0
1 8 3 6 4 778899 5 0 0 0
0 0 0 0 0 0 0 0 0 0
2 2 5 4 2 0 0 7 1 0
0 0 0 0 0 0 0 0 0 0
4 0 7 10 1 0 0 0 0 0
3 10 0 4 3 ddeeff 3 9 0 9
0 0 0 0 0 0 0 0 0 0
1 12 6 4 2 0c0d0e 0 0 0 0
0 0 0 0 0 0 0 0 0 0
